// ==== load_store_unit.f ====
hw/lsu_pkg.sv
hw/ls_addr_gen.sv
hw/ls_scratch_mem.sv
hw/ls_slow_mem.sv
hw/ls_load_return.sv
hw/load_store_unit.sv
sim/load_store_unit_checker.sv
sim/load_store_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/100ps -f load_store_unit.f \
    --top-module load_store_unit_tb -o load_store_unit_sim \
    && ./obj_dir/load_store_unit_sim 2>&1 | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sim/load_store_unit_tb.sv ====
// Inputs change 1 ns after the rising edge; all result checks sit in the bound checker
module load_store_unit_tb import lsu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic          clk;
    logic          rst;
    ls_issue_t     issue;
    logic          issue_valid;
    logic          issue_ready;
    ls_wb_t        wb;
    ls_exception_t exc;
    logic          ls_idle;
    int            seed;
    int            cycles;
    id_t           next_id;
    // About 600 operations at up to 8 cycles each, with margin
    int            cycle_limit = 6000;

    load_store_unit u_dut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic data_t fill_word(input addr_t a);
        return (a * 32'h9E37_79B9) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic fn3_t pick_width(input logic [2:0] sel);
        case (sel)
            3'd0:       return LS_B;
            3'd1:       return LS_H;
            3'd2, 3'd5: return LS_W;
            3'd3, 3'd6: return L_BU;
            default:    return L_HU;
        endcase
    endfunction

    // Holds the request until it is accepted
    task automatic send(input logic is_store, input fn3_t fn3, input addr_t base,
                        input logic [11:0] offset, input data_t value);
        issue.rs1    = base;
        issue.rs2    = value;
        issue.offset = offset;
        issue.fn3    = fn3;
        issue.load   = !is_store;
        issue.store  = is_store;
        issue.id     = next_id;
        issue_valid  = 1'b1;
        @(negedge clk);
        while (!issue_ready) @(negedge clk);
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
        next_id     = next_id + 3'd1;
    endtask

    task automatic read_all(input addr_t base);
        for (int k = 0; k < 4; k++) begin
            send(1'b0, LS_B, base + 32'(k), 12'h0, 32'h0);
            send(1'b0, L_BU, base + 32'(k), 12'h0, 32'h0);
        end
        for (int k = 0; k < 4; k += 2) begin
            send(1'b0, LS_H, base + 32'(k), 12'h0, 32'h0);
            send(1'b0, L_HU, base + 32'(k), 12'h0, 32'h0);
        end
        send(1'b0, LS_W, base, 12'h0, 32'h0);
    endtask

    // Outstanding loads, then room for a slow store to finish
    task automatic drain();
        @(negedge clk);
        while (!ls_idle) @(negedge clk);
        repeat (SLOW_LATENCY + 1) @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // Failure watch and timeout
    always @(negedge clk) begin
        cycles = cycles + 1;
        if (u_dut.u_checker.failed) begin
            $display("Result: FAILED");
            $fatal(1, "an assertion in the checker failed");
        end else if (cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        addr_t       a;
        addr_t       b;
        int          r;
        logic [11:0] off;
        fn3_t        fn3;
        rst         = 1'b1;
        issue       = '0;
        issue_valid = 1'b0;
        seed        = 55816;
        next_id     = '0;
        cycles      = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Known contents for the first 16 words of each memory
        for (int w = 0; w < 32; w++) begin
            a = ((w % 2 == 1) ? SLOW_BASE : SCRATCH_BASE) + 32'(4 * (w / 2));
            send(1'b1, LS_W, a, 12'h0, fill_word(a));
        end

        ////////////////////////////////////////////////////////////
        // Directed cases per unit
        for (int u = 0; u < 2; u++) begin
            b = (u == 1) ? SLOW_BASE : SCRATCH_BASE;
            send(1'b1, LS_W, b + 32'h40, 12'h010, 32'hDEAD_BEEF);
            send(1'b0, LS_W, b + 32'h54, 12'hFFC, 32'h0);
            for (int k = 0; k < 4; k++) send(1'b1, LS_B, b + 32'h4 + 32'(k), 12'h0, $random(seed));
            read_all(b + 32'h4);
            for (int k = 0; k < 4; k += 2) begin
                send(1'b1, LS_H, b + 32'h4 + 32'(k), 12'h0, $random(seed));
            end
            read_all(b + 32'h4);
            // Misaligned accesses, then the word must be unchanged
            send(1'b1, LS_H, b + 32'h8, 12'h001, 32'hFFFF_FFFF);
            send(1'b1, LS_W, b + 32'h8, 12'h002, 32'hFFFF_FFFF);
            send(1'b0, L_HU, b + 32'h8, 12'h003, 32'h0);
            send(1'b0, LS_W, b + 32'h8, 12'h001, 32'h0);
            send(1'b0, LS_W, b + 32'h8, 12'h0, 32'h0);
        end

        // Outside both ranges
        send(1'b0, LS_W, 32'h0000_0800, 12'h0, 32'h0);
        send(1'b1, LS_B, SLOW_BASE + SLOW_SIZE, 12'h0, 32'h0);
        send(1'b0, LS_H, SCRATCH_BASE, 12'hFFE, 32'h0);
        send(1'b1, LS_W, SLOW_BASE, 12'hFFC, 32'h0);
        drain();

        // Alternating units, and scratch stores behind a slow load
        for (int k = 0; k < 6; k++) begin
            send(1'b0, LS_W, SCRATCH_BASE + 32'(4 * k), 12'h0, 32'h0);
            send(1'b0, LS_W, SLOW_BASE + 32'(4 * k), 12'h0, 32'h0);
        end
        send(1'b0, LS_H, SLOW_BASE + 32'h20, 12'h002, 32'h0);
        send(1'b1, LS_W, SCRATCH_BASE + 32'h30, 12'h0, 32'h1234_5678);
        send(1'b1, LS_B, SCRATCH_BASE + 32'h31, 12'h0, 32'h0000_009A);
        send(1'b0, LS_W, SCRATCH_BASE + 32'h30, 12'h0, 32'h0);
        drain();

        ////////////////////////////////////////////////////////////
        // Random mix
        for (int n = 0; n < 400; n++) begin
            r   = $random(seed);
            a   = (r[0] ? SLOW_BASE : SCRATCH_BASE) + 32'({r[4:1], r[6:5]});
            if (r[15:12] == 4'h0) a = 32'h0000_4000 + 32'(r[6:5]);
            off = {{7{r[20]}}, r[20:16]};
            fn3 = pick_width(r[9:7]);
            if (r[10]) fn3 = {1'b0, fn3[1:0]};
            send(r[10], fn3, a - {{20{off[11]}}, off}, off, $random(seed));
        end
        drain();

        if (u_dut.u_checker.failed) begin
            $display("Result: FAILED");
            $fatal(1, "an assertion in the checker failed");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== sim/load_store_unit_checker.sv ====
// Bound to load_store_unit; loads must target words written earlier and use legal fn3 codes
module load_store_unit_checker import lsu_pkg::*; (
    input logic          clk,
    input logic          rst,
    input ls_issue_t     issue,
    input logic          issue_valid,
    input logic          issue_ready,
    input ls_wb_t        wb,
    input ls_exception_t exc,
    input logic          ls_idle
);
    timeunit 1ns;
    timeprecision 100ps;

    data_t            shadow [2][MEM_WORDS];
    id_t              q_id   [4];
    data_t            q_data [4];
    int               q_due  [4];
    logic [1:0]       q_wr;
    logic [1:0]       q_rd;
    logic [2:0]       q_cnt;
    int               cyc;
    int               slow_left;
    logic             out_slow;
    logic             failed = 1'b0;
    logic             accept;
    logic             fault;
    logic             bad_align;
    logic             slow_sel;
    logic             push;
    logic             exp_ready;
    addr_t            addr;
    logic [IDX_W-1:0] idx;
    exc_code_t        exp_code;
    be_t              st_mask;
    data_t            st_data;
    data_t            ld_word;
    data_t            ld_val;

    ////////////////////////////////////////////////////////////
    // Reference decode of the issued operation
    assign accept   = issue_valid && issue_ready;
    assign addr     = issue.rs1 + {{20{issue.offset[11]}}, issue.offset};
    assign idx      = addr[IDX_W+1:2];
    assign slow_sel = (addr >= SLOW_BASE) && (addr < SLOW_BASE + SLOW_SIZE);
    // Scratch range starts at zero, only its upper bound matters
    assign fault    = bad_align || !(slow_sel || addr < SCRATCH_BASE + SCRATCH_SIZE);
    assign push     = accept && !fault && issue.load;
    assign st_data  = issue.rs2 << {addr[1:0], 3'b000};

    // Slow unit busy until its completion cycle, loads held while the other unit has loads out
    assign exp_ready = fault ||
                       (!(slow_sel && slow_left != 0) &&
                        !(issue.load && q_cnt != 3'd0 && out_slow != slow_sel));

    always_comb begin
        bad_align = (issue.fn3[1:0] == 2'b01 && addr[0]) ||
                    (issue.fn3[1:0] == 2'b10 && addr[1:0] != 2'b00);
        exp_code  = bad_align ? (issue.store ? STORE_MISALIGNED : LOAD_MISALIGNED)
                              : (issue.store ? STORE_ACCESS_FAULT : LOAD_ACCESS_FAULT);
        case (issue.fn3[1:0])
            2'b00:   st_mask = 4'b0001;
            2'b01:   st_mask = 4'b0011;
            default: st_mask = 4'b1111;
        endcase
        st_mask = st_mask << addr[1:0];
        ld_word = shadow[slow_sel][idx] >> {addr[1:0], 3'b000};
        case (issue.fn3)
            LS_B:    ld_val = {{24{ld_word[7]}}, ld_word[7:0]};
            LS_H:    ld_val = {{16{ld_word[15]}}, ld_word[15:0]};
            L_BU:    ld_val = {24'b0, ld_word[7:0]};
            L_HU:    ld_val = {16'b0, ld_word[15:0]};
            default: ld_val = ld_word;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Shadow memory and expected-load queue
    always @(posedge clk) begin
        if (rst) begin
            q_wr      <= '0;
            q_rd      <= '0;
            q_cnt     <= '0;
            cyc       <= 0;
            slow_left <= 0;
            out_slow  <= 1'b0;
        end else begin
            cyc <= cyc + 1;
            if (accept && !fault && issue.store) begin
                for (int i = 0; i < 4; i++) begin
                    if (st_mask[i]) shadow[slow_sel][idx][8*i +: 8] <= st_data[8*i +: 8];
                end
            end
            if (accept && !fault && slow_sel) begin
                slow_left <= SLOW_LATENCY;
            end else if (slow_left != 0) begin
                slow_left <= slow_left - 1;
            end
            if (push) begin
                q_id[q_wr]   <= issue.id;
                q_data[q_wr] <= ld_val;
                // Due edge counted from the accept edge
                q_due[q_wr]  <= cyc + (slow_sel ? SLOW_LATENCY + 1 : 1);
                q_wr         <= q_wr + 2'd1;
                out_slow     <= slow_sel;
            end
            if (wb.done) q_rd <= q_rd + 2'd1;
            q_cnt <= q_cnt + 3'(push) - 3'(wb.done);
        end
    end

    ////////////////////////////////////////////////////////////
    // Assertions
    a_issue_ready: assert property (@(posedge clk) disable iff (rst)
        issue_ready == exp_ready)
        else begin
            $error("mismatch at %0t: issue_ready %0b, expected %0b",
                   $time, issue_ready, exp_ready);
            failed = 1'b1;
        end

    a_wb_due: assert property (@(posedge clk) disable iff (rst)
        wb.done |-> q_cnt != 3'd0)
        else begin
            $error("writeback at %0t with no load outstanding", $time);
            failed = 1'b1;
        end

    a_wb_latency: assert property (@(posedge clk) disable iff (rst)
        q_cnt != 3'd0 |-> wb.done == (q_due[q_rd] == cyc))
        else begin
            $error("load result at %0t did not arrive at its due cycle", $time);
            failed = 1'b1;
        end

    a_wb_data: assert property (@(posedge clk) disable iff (rst)
        wb.done |-> wb.id == q_id[q_rd] && wb.data == q_data[q_rd])
        else begin
            $error("mismatch at %0t: id %0d data %h, expected id %0d data %h",
                   $time, wb.id, wb.data, q_id[q_rd], q_data[q_rd]);
            failed = 1'b1;
        end

    a_exc: assert property (@(posedge clk) disable iff (rst)
        exc.valid == (accept && fault) &&
        (!exc.valid || (exc.code == exp_code && exc.tval == addr && exc.id == issue.id)))
        else begin
            $error("mismatch at %0t: exception %0d code %0d tval %h id %0d",
                   $time, exc.valid, exc.code, exc.tval, exc.id);
            failed = 1'b1;
        end

    a_fault_quiet: assert property (@(posedge clk) disable iff (rst)
        accept && fault && q_cnt == 3'd0 |=> !wb.done)
        else begin
            $error("writeback at %0t after a faulting request", $time);
            failed = 1'b1;
        end

    a_idle_reset: assert property (@(posedge clk) $fell(rst) |-> ls_idle)
        else begin
            $error("unit not idle in the cycle after reset at %0t", $time);
            failed = 1'b1;
        end

    a_idle: assert property (@(posedge clk) disable iff (rst)
        ls_idle == (q_cnt == 3'd0))
        else begin
            $error("idle flag at %0t disagrees with the outstanding loads", $time);
            failed = 1'b1;
        end

endmodule

bind load_store_unit load_store_unit_checker u_checker (.*);

// ==== hw/load_store_unit.sv ====
// Load/store unit top; issue is a valid/ready pair, writeback and exceptions cannot stall
module load_store_unit import lsu_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  ls_issue_t     issue,
    input  logic          issue_valid,
    output logic          issue_ready,
    output ls_wb_t        wb,
    output ls_exception_t exc,
    output logic          ls_idle
);

    ls_request_t request;
    logic        scratch_req;
    logic        slow_req;
    logic        scratch_ready;
    logic        slow_ready;
    data_t       scratch_rdata;
    data_t       slow_rdata;
    logic        scratch_valid;
    logic        slow_valid;
    logic        switch_stall;
    logic        ld_push;
    load_attr_t  ld_attr;

    ////////////////////////////////////////////////////////////
    // Address stage
    ls_addr_gen u_addr_gen (
        .issue         (issue),
        .issue_valid   (issue_valid),
        .scratch_ready (scratch_ready),
        .slow_ready    (slow_ready),
        .switch_stall  (switch_stall),
        .issue_ready   (issue_ready),
        .request       (request),
        .scratch_req   (scratch_req),
        .slow_req      (slow_req),
        .ld_push       (ld_push),
        .ld_attr       (ld_attr),
        .exc           (exc)
    );

    ////////////////////////////////////////////////////////////
    // Sub-units
    ls_scratch_mem u_scratch (
        .clk        (clk),
        .rst        (rst),
        .request    (request),
        .req        (scratch_req),
        .ready      (scratch_ready),
        .rdata      (scratch_rdata),
        .data_valid (scratch_valid)
    );

    ls_slow_mem u_slow (
        .clk        (clk),
        .rst        (rst),
        .request    (request),
        .req        (slow_req),
        .ready      (slow_ready),
        .rdata      (slow_rdata),
        .data_valid (slow_valid)
    );

    ////////////////////////////////////////////////////////////
    // Return path
    ls_load_return u_return (
        .clk           (clk),
        .rst           (rst),
        .ld_push       (ld_push),
        .ld_attr       (ld_attr),
        .target_unit   (request.unit),
        .issue_is_load (issue.load),
        .scratch_valid (scratch_valid),
        .scratch_rdata (scratch_rdata),
        .slow_valid    (slow_valid),
        .slow_rdata    (slow_rdata),
        .switch_stall  (switch_stall),
        .wb            (wb),
        .ls_idle       (ls_idle)
    );

endmodule

// ==== hw/ls_load_return.sv ====
// Load return path; relies on the switch stall so that results never arrive out of order
module ls_load_return import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       ld_push,
    input  load_attr_t ld_attr,
    input  unit_t      target_unit,
    input  logic       issue_is_load,
    input  logic       scratch_valid,
    input  data_t      scratch_rdata,
    input  logic       slow_valid,
    input  data_t      slow_rdata,
    output logic       switch_stall,
    output ls_wb_t     wb,
    output logic       ls_idle
);

    load_attr_t            attr_mem [ATTR_DEPTH];
    logic [ATTR_PTR_W-1:0] wr_ptr;
    logic [ATTR_PTR_W-1:0] rd_ptr;
    logic [ATTR_CNT_W-1:0] count;
    logic                  empty;
    logic                  pop;
    load_attr_t            head;
    data_t                 word;
    logic [15:0]           half_sel;
    logic [7:0]            byte_sel;
    data_t                 ext_data;

    ////////////////////////////////////////////////////////////
    // Attributes FIFO
    assign empty = (count == '0);
    assign pop   = scratch_valid || slow_valid;
    assign head  = attr_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (ld_push) attr_mem[wr_ptr] <= ld_attr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (ld_push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (ld_push && !pop) count <= count + 1'b1;
            else if (pop && !ld_push) count <= count - 1'b1;
        end
    end

    assign ls_idle = empty;

    // Hold a load for the other unit until all outstanding loads are back
    assign switch_stall = issue_is_load && !empty && (target_unit != head.unit);

    ////////////////////////////////////////////////////////////
    // Data select, alignment and extension
    assign word = (head.unit == UNIT_SLOW) ? slow_rdata : scratch_rdata;

    // Halfword first, then byte within it
    assign half_sel = head.byte_addr[1] ? word[31:16] : word[15:0];
    assign byte_sel = head.byte_addr[0] ? half_sel[15:8] : half_sel[7:0];

    always_comb begin
        case (head.fn3)
            LS_B:    ext_data = {{24{byte_sel[7]}}, byte_sel};
            LS_H:    ext_data = {{16{half_sel[15]}}, half_sel};
            L_BU:    ext_data = {24'b0, byte_sel};
            L_HU:    ext_data = {16'b0, half_sel};
            default: ext_data = word;
        endcase
    end

    assign wb.done = pop;
    assign wb.id   = head.id;
    assign wb.data = ext_data;

endmodule

// ==== hw/ls_slow_mem.sv ====
// Fixed-latency memory, one request at a time, new request only while ready is high
module ls_slow_mem import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ls_request_t request,
    input  logic        req,
    output logic        ready,
    output data_t       rdata,
    output logic        data_valid
);

    data_t                 mem [MEM_WORDS];
    ls_request_t           pend;
    slow_state_t           state;
    logic [SLOW_CNT_W-1:0] count;
    logic                  last;
    logic [IDX_W-1:0]      idx;

    assign idx   = pend.addr[IDX_W+1:2];
    assign last  = (state == SLOW_BUSY) && (count == SLOW_CNT_W'(SLOW_LATENCY - 1));
    assign ready = (state == SLOW_IDLE);

    ////////////////////////////////////////////////////////////
    // Control FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SLOW_IDLE;
            count      <= '0;
            data_valid <= 1'b0;
        end else begin
            data_valid <= last && pend.load;
            case (state)
                SLOW_IDLE: begin
                    count <= '0;
                    if (req) state <= SLOW_BUSY;
                end
                SLOW_BUSY: begin
                    count <= count + 1'b1;
                    if (last) state <= SLOW_IDLE;
                end
                default: state <= SLOW_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Request latch and storage access at the final count
    always_ff @(posedge clk) begin
        if (req && ready) pend <= request;
        if (last && pend.store) begin
            for (int i = 0; i < 4; i++) begin
                if (pend.be[i]) mem[idx][8*i +: 8] <= pend.wdata[8*i +: 8];
            end
        end
        if (last && pend.load) rdata <= mem[idx];
    end

endmodule

// ==== hw/ls_scratch_mem.sv ====
// Single-cycle scratch memory, contents undefined after power-up, offset bits above 9 ignored
module ls_scratch_mem import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ls_request_t request,
    input  logic        req,
    output logic        ready,
    output data_t       rdata,
    output logic        data_valid
);

    data_t            mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;

    assign idx = request.addr[IDX_W+1:2];

    // Pipelined, so always able to take a request
    assign ready = 1'b1;

    ////////////////////////////////////////////////////////////
    // Storage
    always_ff @(posedge clk) begin
        if (req && request.store) begin
            for (int i = 0; i < 4; i++) begin
                if (request.be[i]) begin
                    mem[idx][8*i +: 8] <= request.wdata[8*i +: 8];
                end
            end
        end
        if (req && request.load) begin
            rdata <= mem[idx];
        end
    end

    // One cycle after the load request
    always_ff @(posedge clk) begin
        if (rst) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= req && request.load;
        end
    end

endmodule

// ==== hw/ls_addr_gen.sv ====
// Combinational issue stage; expects exactly one of load or store set on a valid issue
module ls_addr_gen import lsu_pkg::*; (
    input  ls_issue_t     issue,
    input  logic          issue_valid,
    input  logic          scratch_ready,
    input  logic          slow_ready,
    input  logic          switch_stall,
    output logic          issue_ready,
    output ls_request_t   request,
    output logic          scratch_req,
    output logic          slow_req,
    output logic          ld_push,
    output load_attr_t    ld_attr,
    output ls_exception_t exc
);

    addr_t addr;
    logic  misaligned;
    logic  in_scratch;
    logic  in_slow;
    logic  fault;
    logic  unit_ready;
    logic  accept;
    be_t   be;
    data_t wdata;

    ////////////////////////////////////////////////////////////
    // Address and checks
    assign addr = issue.rs1 + {{20{issue.offset[11]}}, issue.offset};

    always_comb begin
        case (issue.fn3)
            LS_H, L_HU: misaligned = addr[0];
            LS_W:       misaligned = |addr[1:0];
            default:    misaligned = 1'b0;
        endcase
    end

    // Unsigned wrap makes one compare per range enough
    assign in_scratch = (addr - SCRATCH_BASE) < SCRATCH_SIZE;
    assign in_slow    = (addr - SLOW_BASE) < SLOW_SIZE;
    assign fault      = misaligned || !(in_scratch || in_slow);

    ////////////////////////////////////////////////////////////
    // Byte enables and lane replication of store data
    always_comb begin
        be    = '0;
        wdata = issue.rs2;
        case (issue.fn3[1:0])
            LS_B[1:0]: begin
                be[addr[1:0]] = 1'b1;
                wdata = {4{issue.rs2[7:0]}};
            end
            LS_H[1:0]: begin
                be[{addr[1], 1'b0}] = 1'b1;
                be[{addr[1], 1'b1}] = 1'b1;
                wdata = {2{issue.rs2[15:0]}};
            end
            default: be = '1;
        endcase
        be &= {4{issue.store}};
    end

    assign request.addr  = addr;
    assign request.be    = be;
    assign request.wdata = wdata;
    assign request.load  = issue.load;
    assign request.store = issue.store;
    assign request.unit  = in_slow ? UNIT_SLOW : UNIT_SCRATCH;

    ////////////////////////////////////////////////////////////
    // Acceptance and strobes
    assign unit_ready  = (request.unit == UNIT_SLOW) ? slow_ready : scratch_ready;
    // Faulting requests never touch a sub-unit
    assign issue_ready = fault || (unit_ready && !switch_stall);
    assign accept      = issue_valid && issue_ready;

    assign scratch_req = accept && !fault && (request.unit == UNIT_SCRATCH);
    assign slow_req    = accept && !fault && (request.unit == UNIT_SLOW);
    assign ld_push     = accept && !fault && issue.load;

    assign ld_attr.fn3       = issue.fn3;
    assign ld_attr.byte_addr = addr[1:0];
    assign ld_attr.id        = issue.id;
    assign ld_attr.unit      = request.unit;

    // Alignment takes priority over range
    assign exc.valid = accept && fault;
    assign exc.code  = misaligned ? (issue.store ? STORE_MISALIGNED : LOAD_MISALIGNED)
                                  : (issue.store ? STORE_ACCESS_FAULT : LOAD_ACCESS_FAULT);
    assign exc.tval  = addr;
    assign exc.id    = issue.id;

endmodule

// ==== hw/lsu_pkg.sv ====
// Fixed address map and latencies, no run-time configuration, identity addressing only
package lsu_pkg;

    ////////////////////////////////////////////////////////////
    // Widths with a meaning
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [2:0]  id_t;
    typedef logic [2:0]  fn3_t;
    typedef logic [3:0]  be_t;
    typedef logic        unit_t;
    typedef logic [3:0]  exc_code_t;

    // RISC-V load/store width codes
    localparam fn3_t LS_B = 3'b000;
    localparam fn3_t LS_H = 3'b001;
    localparam fn3_t LS_W = 3'b010;
    localparam fn3_t L_BU = 3'b100;
    localparam fn3_t L_HU = 3'b101;

    // Sub-unit index
    localparam unit_t UNIT_SCRATCH = 1'b0;
    localparam unit_t UNIT_SLOW    = 1'b1;

    // Exception causes
    localparam exc_code_t LOAD_MISALIGNED    = 4'd4;
    localparam exc_code_t LOAD_ACCESS_FAULT  = 4'd5;
    localparam exc_code_t STORE_MISALIGNED   = 4'd6;
    localparam exc_code_t STORE_ACCESS_FAULT = 4'd7;

    ////////////////////////////////////////////////////////////
    // Address map and sizing
    localparam addr_t SCRATCH_BASE = 32'h0000_0000;
    localparam addr_t SCRATCH_SIZE = 32'h0000_0400;
    localparam addr_t SLOW_BASE    = 32'h0001_0000;
    localparam addr_t SLOW_SIZE    = 32'h0000_0400;

    localparam int MEM_WORDS    = 256;
    localparam int IDX_W        = $clog2(MEM_WORDS);
    localparam int SLOW_LATENCY = 3;
    localparam int SLOW_CNT_W   = $clog2(SLOW_LATENCY);
    localparam int ATTR_DEPTH   = 2;
    localparam int ATTR_PTR_W   = $clog2(ATTR_DEPTH);
    localparam int ATTR_CNT_W   = $clog2(ATTR_DEPTH + 1);

    ////////////////////////////////////////////////////////////
    // Bundles
    typedef struct packed {
        data_t       rs1;
        data_t       rs2;
        logic [11:0] offset;
        fn3_t        fn3;
        logic        load;
        logic        store;
        id_t         id;
    } ls_issue_t;

    typedef struct packed {
        addr_t addr;
        be_t   be;
        data_t wdata;
        logic  load;
        logic  store;
        unit_t unit;
    } ls_request_t;

    typedef struct packed {
        fn3_t       fn3;
        logic [1:0] byte_addr;
        id_t        id;
        unit_t      unit;
    } load_attr_t;

    typedef struct packed {
        logic  done;
        id_t   id;
        data_t data;
    } ls_wb_t;

    typedef struct packed {
        logic      valid;
        exc_code_t code;
        addr_t     tval;
        id_t       id;
    } ls_exception_t;

    typedef enum logic {
        SLOW_IDLE,
        SLOW_BUSY
    } slow_state_t;

endpackage
